/* hdl/imager_defines.svh */
`ifndef IMAGER_DEFINES_SVH
`define IMAGER_DEFINES_SVH

// sensor pixel bus width
`define PIXEL_WIDTH 12

// stream data word carried with every type code
`define DATA_WIDTH 16

// row and column counters
`define DIM_WIDTH 16

// output buffer entries
`define FIFO_DEPTH 8

// credits granted to the downstream consumer out of reset
`define FIFO_CREDITS 4

// fill level that holds off header words
`define STALL_LEVEL (`FIFO_DEPTH - 2)

// header data words between header start and header end
`define HDR_WORDS 9

// register bus widths
`define REG_DATA_WIDTH 16
`define REG_ADDR_WIDTH 8

`endif

/* hdl/stream_pkg.sv */
package stream_pkg;

   // type code carried with each stream word
   // nine codes so four bits
   typedef enum logic [3:0] {
      dtype_none         = 4'd0,
      dtype_pixel        = 4'd1,
      dtype_frame_start  = 4'd2,
      dtype_frame_end    = 4'd3,
      dtype_row_start    = 4'd4,
      dtype_row_end      = 4'd5,
      dtype_header_start = 4'd6,
      dtype_header       = 4'd7,
      dtype_header_end   = 4'd8
   } dtype_t;

   // header word index, in the order the words leave
   typedef enum logic [3:0] {
      hdr_sync_hi,
      hdr_sync_lo,
      hdr_version,
      hdr_num_rows,
      hdr_num_cols,
      hdr_frame_count,
      hdr_clks_hi,
      hdr_clks_lo,
      hdr_checksum
   } hdr_idx_t;

   // fixed header content
   localparam logic [15:0] sync_hi_word   = 16'hffff;
   localparam logic [15:0] sync_lo_word   = 16'hfffe;
   localparam logic [15:0] header_version = 16'd2;

endpackage

/* hdl/reg_pkg.sv */
`include "imager_defines.svh"

package reg_pkg;

   // register map
   typedef enum logic [`REG_ADDR_WIDTH-1:0] {
      reg_addr_ctrl         = 0,
      reg_addr_status       = 1,
      reg_addr_frame_count  = 2,
      reg_addr_num_rows     = 3,
      reg_addr_num_cols     = 4,
      reg_addr_clks_per_row = 5,
      reg_addr_checksum     = 6
   } reg_addr_t;

   // bus status returned next to every read
   typedef enum logic [`REG_DATA_WIDTH-1:0] {
      reg_err_ok       = 'h0000,
      reg_err_bad_addr = 'hfffd
   } reg_err_t;

   // read data for an address outside the map
   localparam logic [`REG_DATA_WIDTH-1:0] reg_bad_data = 'haaaa;

   // bit positions inside ctrl and status
   localparam int ctrl_enable_bit     = 0;
   localparam int status_overflow_bit = 0;

endpackage

/* hdl/imager_rx.sv */
`timescale 1ns/10ps
`include "imager_defines.svh"

module imager_rx
   import stream_pkg::*;
(
   input  logic                    clki,
   input  logic                    resetb,
   input  logic                    enable,
   input  logic                    fv,
   input  logic                    lv,
   input  logic [`PIXEL_WIDTH-1:0] pixel,
   input  logic                    hdr_stall,
   input  logic [`DATA_WIDTH-1:0]  hdr_word,
   output logic                    rx_valid,
   output dtype_t                  rx_dtype,
   output logic [`DATA_WIDTH-1:0]  rx_data,
   output hdr_idx_t                hdr_idx,
   output logic [15:0]             frame_count,
   output logic [`DIM_WIDTH-1:0]   num_rows,
   output logic [`DIM_WIDTH-1:0]   num_cols,
   output logic [15:0]             clks_per_row,
   output logic [15:0]             checksum,
   output logic [31:0]             clks_per_frame
);

   typedef enum logic [1:0] {
      hs_idle,
      hs_start,
      hs_body,
      hs_end
   } hdr_state_t;

   // two sync flops then one delay stage for edge detection
   logic                    fv_s1, fv_s2, fv_s3;
   logic                    lv_s1, lv_s2, lv_s3;
   logic [`PIXEL_WIDTH-1:0] pix_s1, pix_s2, pix_s3;
   logic                    fv_fall_d, lv_fall_d;
   logic                    enable_s;
   logic                    waiting;
   hdr_state_t              hdr_state;
   logic [`DIM_WIDTH-1:0]   row_count, col_count;
   logic [31:0]             frame_clks;
   logic [15:0]             row_clks;

   // edges seen one stage ahead of the pixel qualifier
   // so a start marker always lands before its first pixel
   wire fv_rise = fv_s2 && !fv_s3;
   wire fv_fall = !fv_s2 && fv_s3;
   wire lv_rise = lv_s2 && !lv_s3;
   wire lv_fall = !lv_s2 && lv_s3;
   wire dv      = fv_s3 && lv_s3;

   // framing and word emission
   always_ff @(posedge clki or negedge resetb) begin
      if (!resetb) begin
         {fv_s1, fv_s2, fv_s3} <= '0;
         {lv_s1, lv_s2, lv_s3} <= '0;
         {pix_s1, pix_s2, pix_s3} <= '0;
         fv_fall_d <= 1'b0;
         lv_fall_d <= 1'b0;
         enable_s  <= 1'b0;
         waiting   <= 1'b1;
         hdr_state <= hs_idle;
         hdr_idx   <= hdr_sync_hi;
         rx_valid  <= 1'b0;
         rx_dtype  <= dtype_none;
         rx_data   <= '0;
         checksum  <= '0;
      end else begin
         fv_s1  <= fv;
         fv_s2  <= fv_s1;
         fv_s3  <= fv_s2;
         lv_s1  <= lv;
         lv_s2  <= lv_s1;
         lv_s3  <= lv_s2;
         pix_s1 <= pixel;
         pix_s2 <= pix_s1;
         pix_s3 <= pix_s2;
         fv_fall_d <= fv_fall;
         lv_fall_d <= lv_fall;
         // single register on enable, software side is slow
         enable_s <= enable;
         rx_valid <= 1'b0;

         if (!enable_s || waiting) begin
            // hold off until enabled and fv quiet in all three stages
            // so no partial frame enters the stream
            waiting   <= !enable_s || fv_s1 || fv_s2 || fv_s3;
            hdr_state <= hs_idle;
            checksum  <= '0;
         end else if (dv) begin
            // pixel has top priority, zero extended
            rx_valid <= 1'b1;
            rx_dtype <= dtype_pixel;
            rx_data  <= `DATA_WIDTH'(pix_s3);
            checksum <= checksum + 16'(pix_s3);
         end else if (fv_rise) begin
            rx_valid <= 1'b1;
            rx_dtype <= dtype_frame_start;
            rx_data  <= frame_count;
            checksum <= '0;
         end else if (fv_fall_d) begin
            // frame end arms the header sequence
            rx_valid  <= 1'b1;
            rx_dtype  <= dtype_frame_end;
            rx_data   <= '0;
            hdr_state <= hs_start;
            hdr_idx   <= hdr_sync_hi;
         end else if (lv_rise) begin
            rx_valid <= 1'b1;
            rx_dtype <= dtype_row_start;
            rx_data  <= `DATA_WIDTH'(row_count);
         end else if (lv_fall_d) begin
            rx_valid <= 1'b1;
            rx_dtype <= dtype_row_end;
            rx_data  <= '0;
         end else if (hdr_state != hs_idle && !hdr_stall) begin
            // every header word waits while the buffer is nearly full
            rx_valid <= 1'b1;
            case (hdr_state)
               hs_start: begin
                  rx_dtype  <= dtype_header_start;
                  rx_data   <= '0;
                  hdr_state <= hs_body;
               end
               hs_body: begin
                  rx_dtype <= dtype_header;
                  rx_data  <= hdr_word;
                  hdr_idx  <= hdr_idx_t'(hdr_idx + 4'd1);
                  if (hdr_idx == hdr_idx_t'(`HDR_WORDS - 1)) begin
                     hdr_state <= hs_end;
                  end
               end
               default: begin
                  rx_dtype  <= dtype_header_end;
                  rx_data   <= '0;
                  hdr_state <= hs_idle;
               end
            endcase
         end
      end
   end

   // frame statistics, free running
   always_ff @(posedge clki or negedge resetb) begin
      if (!resetb) begin
         frame_count    <= '0;
         frame_clks     <= '0;
         clks_per_frame <= '0;
         row_count      <= '0;
         col_count      <= '0;
         num_rows       <= '0;
         num_cols       <= '0;
         row_clks       <= '0;
         clks_per_row   <= '0;
      end else begin
         if (fv_rise) begin
            frame_count    <= frame_count + 1'b1;
            clks_per_frame <= frame_clks + 1'b1;
            frame_clks     <= '0;
            row_count      <= '0;
         end else begin
            frame_clks <= frame_clks + 1'b1;
            if (lv_fall) begin
               row_count <= row_count + 1'b1;
            end
         end

         if (lv_rise) begin
            col_count <= '0;
         end else if (dv) begin
            col_count <= col_count + 1'b1;
         end

         // delayed fall so the last pixel is already counted
         if (fv_fall_d) begin
            num_rows <= row_count;
            num_cols <= col_count;
         end

         // row period measured rise to rise inside the frame
         if (fv_s2) begin
            if (lv_rise) begin
               clks_per_row <= row_clks + 1'b1;
               row_clks     <= '0;
            end else begin
               row_clks <= row_clks + 1'b1;
            end
         end
      end
   end

endmodule

/* hdl/image_header.sv */
`timescale 1ns/10ps
`include "imager_defines.svh"

module image_header
   import stream_pkg::*;
(
   input  hdr_idx_t                hdr_idx,
   input  logic [`DIM_WIDTH-1:0]   num_rows,
   input  logic [`DIM_WIDTH-1:0]   num_cols,
   input  logic [15:0]             frame_count,
   input  logic [31:0]             clks_per_frame,
   input  logic [15:0]             checksum,
   output logic [`DATA_WIDTH-1:0]  hdr_word
);

   // one word per index, looked up the same cycle
   always_comb begin
      case (hdr_idx)
         // sync pattern marks the block for a parser
         hdr_sync_hi:     hdr_word = sync_hi_word;
         hdr_sync_lo:     hdr_word = sync_lo_word;
         hdr_version:     hdr_word = header_version;
         hdr_num_rows:    hdr_word = `DATA_WIDTH'(num_rows);
         hdr_num_cols:    hdr_word = `DATA_WIDTH'(num_cols);
         hdr_frame_count: hdr_word = frame_count;
         // frame clock count split high word first
         hdr_clks_hi:     hdr_word = clks_per_frame[31:16];
         hdr_clks_lo:     hdr_word = clks_per_frame[15:0];
         hdr_checksum:    hdr_word = checksum;
         // past the last word
         default:         hdr_word = '0;
      endcase
   end

endmodule

/* hdl/reg_port.sv */
`timescale 1ns/10ps
`include "imager_defines.svh"

module reg_port
   import reg_pkg::*;
(
   input  logic                       clki,
   input  logic                       resetb,
   input  logic [`REG_ADDR_WIDTH-1:0] reg_addr,
   input  logic                       reg_wr,
   input  logic [`REG_DATA_WIDTH-1:0] reg_wdata,
   input  logic                       reg_rd,
   input  logic                       overflow,
   input  logic [15:0]                frame_count,
   input  logic [`DIM_WIDTH-1:0]      num_rows,
   input  logic [`DIM_WIDTH-1:0]      num_cols,
   input  logic [15:0]                clks_per_row,
   input  logic [15:0]                checksum,
   output logic [`REG_DATA_WIDTH-1:0] reg_rdata,
   output logic [`REG_DATA_WIDTH-1:0] reg_status,
   output logic                       enable,
   output logic                       overflow_clr
);

   wire reg_addr_t addr = reg_addr_t'(reg_addr);

   // control register, write lands at the next clock
   always_ff @(posedge clki or negedge resetb) begin
      if (!resetb) begin
         enable <= 1'b0;
      end else if (reg_wr && addr == reg_addr_ctrl) begin
         enable <= reg_wdata[ctrl_enable_bit];
      end
   end

   // reading status clears the sticky overflow in the buffer
   assign overflow_clr = reg_rd && (addr == reg_addr_status);

   // read mux, purely from the address
   always_comb begin
      reg_rdata  = '0;
      reg_status = reg_err_ok;
      case (addr)
         reg_addr_ctrl:         reg_rdata[ctrl_enable_bit] = enable;
         reg_addr_status:       reg_rdata[status_overflow_bit] = overflow;
         reg_addr_frame_count:  reg_rdata = `REG_DATA_WIDTH'(frame_count);
         reg_addr_num_rows:     reg_rdata = `REG_DATA_WIDTH'(num_rows);
         reg_addr_num_cols:     reg_rdata = `REG_DATA_WIDTH'(num_cols);
         reg_addr_clks_per_row: reg_rdata = `REG_DATA_WIDTH'(clks_per_row);
         reg_addr_checksum:     reg_rdata = `REG_DATA_WIDTH'(checksum);
         default: begin
            // unmapped address
            reg_rdata  = reg_bad_data;
            reg_status = reg_err_bad_addr;
         end
      endcase
   end

endmodule

/* hdl/credit_fifo.sv */
`timescale 1ns/10ps
`include "imager_defines.svh"

module credit_fifo
   import stream_pkg::*;
(
   input  logic                   clki,
   input  logic                   resetb,
   input  logic                   rx_valid,
   input  dtype_t                 rx_dtype,
   input  logic [`DATA_WIDTH-1:0] rx_data,
   input  logic                   credit_return,
   input  logic                   overflow_clr,
   output logic                   hdr_stall,
   output logic                   overflow,
   output logic                   out_valid,
   output dtype_t                 out_dtype,
   output logic [`DATA_WIDTH-1:0] out_data
);

   localparam int ptr_w  = $clog2(`FIFO_DEPTH);
   localparam int cnt_w  = $clog2(`FIFO_DEPTH + 1);
   localparam int cred_w = $clog2(`FIFO_CREDITS + 1);

   dtype_t                 mem_dtype [`FIFO_DEPTH];
   logic [`DATA_WIDTH-1:0] mem_data  [`FIFO_DEPTH];
   logic [ptr_w-1:0]       wr_ptr, rd_ptr;
   logic [cnt_w-1:0]       fill;
   logic [cred_w-1:0]      credits;
   logic                   full, wr_en, send;

   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
      return (ptr == ptr_w'(`FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full  = (fill == cnt_w'(`FIFO_DEPTH));
   // the writer cannot wait, a full buffer drops the word
   assign wr_en = rx_valid && !full;
   // head leaves only with a word queued and a credit in hand
   assign send  = (fill != '0) && (credits != '0);
   // nearly full holds off the header words upstream
   assign hdr_stall = (fill >= cnt_w'(`STALL_LEVEL));

   always_ff @(posedge clki or negedge resetb) begin
      if (!resetb) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill      <= '0;
         credits   <= cred_w'(`FIFO_CREDITS);
         overflow  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         out_valid <= send;
         if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (send) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({wr_en, send})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
         // send and return together cancel
         case ({send, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
         // sticky until software reads status, a new drop wins
         if (overflow_clr) begin
            overflow <= 1'b0;
         end
         if (rx_valid && full) begin
            overflow <= 1'b1;
         end
      end
   end

   // storage and output word
   always_ff @(posedge clki) begin
      if (wr_en) begin
         mem_dtype[wr_ptr] <= rx_dtype;
         mem_data[wr_ptr]  <= rx_data;
      end
      if (send) begin
         out_dtype <= mem_dtype[rd_ptr];
         out_data  <= mem_data[rd_ptr];
      end
   end

endmodule

/* hdl/imager_top.sv */
`timescale 1ns/10ps
`include "imager_defines.svh"

module imager_top
   import stream_pkg::*;
(
   input  logic                       clki,
   input  logic                       resetb,
   input  logic                       fv,
   input  logic                       lv,
   input  logic [`PIXEL_WIDTH-1:0]    pixel,
   input  logic [`REG_ADDR_WIDTH-1:0] reg_addr,
   input  logic                       reg_wr,
   input  logic [`REG_DATA_WIDTH-1:0] reg_wdata,
   input  logic                       reg_rd,
   output logic [`REG_DATA_WIDTH-1:0] reg_rdata,
   output logic [`REG_DATA_WIDTH-1:0] reg_status,
   output logic                       out_valid,
   output dtype_t                     out_dtype,
   output logic [`DATA_WIDTH-1:0]     out_data,
   input  logic                       credit_return
);

   // control between register port and datapath
   logic                   enable, overflow, overflow_clr;
   // receiver to buffer stream
   logic                   rx_valid, hdr_stall;
   dtype_t                 rx_dtype;
   logic [`DATA_WIDTH-1:0] rx_data;
   // header lookup
   hdr_idx_t               hdr_idx;
   logic [`DATA_WIDTH-1:0] hdr_word;
   // frame statistics
   logic [15:0]            frame_count, clks_per_row, checksum;
   logic [`DIM_WIDTH-1:0]  num_rows, num_cols;
   logic [31:0]            clks_per_frame;

   imager_rx u_imager_rx (
      .clki           (clki),
      .resetb         (resetb),
      .enable         (enable),
      .fv             (fv),
      .lv             (lv),
      .pixel          (pixel),
      .hdr_stall      (hdr_stall),
      .hdr_word       (hdr_word),
      .rx_valid       (rx_valid),
      .rx_dtype       (rx_dtype),
      .rx_data        (rx_data),
      .hdr_idx        (hdr_idx),
      .frame_count    (frame_count),
      .num_rows       (num_rows),
      .num_cols       (num_cols),
      .clks_per_row   (clks_per_row),
      .checksum       (checksum),
      .clks_per_frame (clks_per_frame)
   );

   image_header u_image_header (
      .hdr_idx        (hdr_idx),
      .num_rows       (num_rows),
      .num_cols       (num_cols),
      .frame_count    (frame_count),
      .clks_per_frame (clks_per_frame),
      .checksum       (checksum),
      .hdr_word       (hdr_word)
   );

   reg_port u_reg_port (
      .clki         (clki),
      .resetb       (resetb),
      .reg_addr     (reg_addr),
      .reg_wr       (reg_wr),
      .reg_wdata    (reg_wdata),
      .reg_rd       (reg_rd),
      .overflow     (overflow),
      .frame_count  (frame_count),
      .num_rows     (num_rows),
      .num_cols     (num_cols),
      .clks_per_row (clks_per_row),
      .checksum     (checksum),
      .reg_rdata    (reg_rdata),
      .reg_status   (reg_status),
      .enable       (enable),
      .overflow_clr (overflow_clr)
   );

   credit_fifo u_credit_fifo (
      .clki          (clki),
      .resetb        (resetb),
      .rx_valid      (rx_valid),
      .rx_dtype      (rx_dtype),
      .rx_data       (rx_data),
      .credit_return (credit_return),
      .overflow_clr  (overflow_clr),
      .hdr_stall     (hdr_stall),
      .overflow      (overflow),
      .out_valid     (out_valid),
      .out_dtype     (out_dtype),
      .out_data      (out_data)
   );

endmodule

/* bench/imager_top_tb.sv */
`timescale 1ns/10ps
`include "imager_defines.svh"

module imager_top_tb
   import stream_pkg::*;
   import reg_pkg::*;
();

   localparam int half_period = 50;
   // cycle budget of each test
   localparam int t1_cycles = 400;
   localparam int t2_cycles = 400;
   localparam int t3_cycles = 600;
   localparam int t4_cycles = 800;
   localparam int t5_cycles = 800;
   localparam int watchdog_cycles =
      16 + t1_cycles + t2_cycles + t3_cycles + t4_cycles + t5_cycles + 1000;
   // register bus responses from the address map
   localparam logic [15:0] status_ok       = 16'h0000;
   localparam logic [15:0] status_bad_addr = 16'hfffd;
   localparam logic [15:0] unmapped_data   = 16'haaaa;

   logic                       clki, resetb, fv, lv;
   logic [`PIXEL_WIDTH-1:0]    pixel;
   logic [`REG_ADDR_WIDTH-1:0] reg_addr;
   logic                       reg_wr, reg_rd;
   logic [`REG_DATA_WIDTH-1:0] reg_wdata, reg_rdata, reg_status;
   logic                       out_valid;
   dtype_t                     out_dtype;
   logic [`DATA_WIDTH-1:0]     out_data;
   logic                       credit_return = 1'b0;

   integer seed = 32'he10bc34c;
   int     errors = 0;
   int     checks = 0;
   int     cycle_count = 0;
   // consumer side credit bookkeeping
   bit     withhold = 1'b0;
   int     owed = 0;
   bit     ret_d1 = 1'b0, ret_d2 = 1'b0;
   // received and expected stream
   dtype_t      got_type[$], exp_type[$];
   logic [15:0] got_data[$], exp_data[$];
   bit          exp_chk[$];
   // record of the last frame the sensor model played
   int                      frames_driven = 0;
   int                      prev_rise = 0;
   int                      last_rows, last_cols, last_gap, last_index;
   logic [31:0]             last_clks;
   logic [`PIXEL_WIDTH-1:0] last_pix[$];

   imager_top u_imager_top (
      .clki          (clki),
      .resetb        (resetb),
      .fv            (fv),
      .lv            (lv),
      .pixel         (pixel),
      .reg_addr      (reg_addr),
      .reg_wr        (reg_wr),
      .reg_wdata     (reg_wdata),
      .reg_rd        (reg_rd),
      .reg_rdata     (reg_rdata),
      .reg_status    (reg_status),
      .out_valid     (out_valid),
      .out_dtype     (out_dtype),
      .out_data      (out_data),
      .credit_return (credit_return)
   );

   initial begin
      clki = 1'b0;
      forever #half_period clki = ~clki;
   end

   always @(posedge clki) begin
      cycle_count <= cycle_count + 1;
   end

   // consumer model returns one credit two cycles after each word
   always @(negedge clki) begin
      if (out_valid) begin
         got_type.push_back(out_dtype);
         got_data.push_back(out_data);
      end
      if (ret_d2) begin
         owed = owed + 1;
      end
      ret_d2 = ret_d1;
      ret_d1 = out_valid;
      // withheld credits pile up and come back one per cycle later
      if (!withhold && owed > 0) begin
         credit_return = 1'b1;
         owed = owed - 1;
      end else begin
         credit_return = 1'b0;
      end
   end

   task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
      @(negedge clki);
      reg_addr  = addr;
      reg_wdata = data;
      reg_wr    = 1'b1;
      @(negedge clki);
      reg_wr = 1'b0;
   endtask

   task automatic check_reg(input logic [7:0] addr, input logic [15:0] exp_d,
                            input logic [15:0] exp_s, input string what);
      logic [15:0] d, s;
      @(negedge clki);
      reg_addr = addr;
      reg_rd   = 1'b1;
      // read data is combinational and sampled mid low phase
      #(half_period / 2);
      d = reg_rdata;
      s = reg_status;
      @(negedge clki);
      reg_rd = 1'b0;
      checks++;
      assert (d == exp_d && s == exp_s) else begin
         errors++;
         $display("Fail %0t: %s read %h status %h, expected %h status %h",
                  $time, what, d, s, exp_d, exp_s);
      end
   endtask

   // sensor model keeps lv low before fv falls
   task automatic play_frame(input int rows, input int cols, input int row_gap);
      logic [`PIXEL_WIDTH-1:0] p;
      @(negedge clki);
      fv = 1'b1;
      last_index = frames_driven;
      last_clks  = 32'(cycle_count - prev_rise);
      prev_rise  = cycle_count;
      frames_driven++;
      last_rows = rows;
      last_cols = cols;
      last_gap  = row_gap;
      last_pix.delete();
      repeat (3) @(negedge clki);
      for (int r = 0; r < rows; r++) begin
         for (int c = 0; c < cols; c++) begin
            @(negedge clki);
            p = `PIXEL_WIDTH'($random(seed));
            lv    = 1'b1;
            pixel = p;
            last_pix.push_back(p);
         end
         repeat (row_gap) begin
            @(negedge clki);
            lv    = 1'b0;
            pixel = '0;
         end
      end
      repeat (2) @(negedge clki);
      @(negedge clki);
      fv = 1'b0;
      // quiet time for the header
      repeat (24) @(negedge clki);
   endtask

   function automatic logic [15:0] pixel_sum();
      logic [15:0] sum;
      sum = '0;
      foreach (last_pix[i]) begin
         sum = sum + 16'(last_pix[i]);
      end
      return sum;
   endfunction

   task automatic push_word(input dtype_t t, input logic [15:0] d, input bit chk);
      exp_type.push_back(t);
      exp_data.push_back(d);
      exp_chk.push_back(chk);
   endtask

   // expected words of the last frame played
   task automatic expect_frame();
      int k;
      k = 0;
      push_word(dtype_frame_start, 16'(last_index), 1'b1);
      for (int r = 0; r < last_rows; r++) begin
         push_word(dtype_row_start, 16'(r), 1'b1);
         for (int c = 0; c < last_cols; c++) begin
            push_word(dtype_pixel, 16'(last_pix[k]), 1'b1);
            k++;
         end
         push_word(dtype_row_end, '0, 1'b0);
      end
      push_word(dtype_frame_end, '0, 1'b0);
      push_word(dtype_header_start, '0, 1'b0);
      push_word(dtype_header, 16'hffff, 1'b1);
      push_word(dtype_header, 16'hfffe, 1'b1);
      push_word(dtype_header, 16'h0002, 1'b1);
      push_word(dtype_header, 16'(last_rows), 1'b1);
      push_word(dtype_header, 16'(last_cols), 1'b1);
      // count includes this frame by header time
      push_word(dtype_header, 16'(last_index + 1), 1'b1);
      push_word(dtype_header, last_clks[31:16], 1'b1);
      push_word(dtype_header, last_clks[15:0], 1'b1);
      push_word(dtype_header, pixel_sum(), 1'b1);
      push_word(dtype_header_end, '0, 1'b0);
   endtask

   task automatic wait_words(input int n, input int limit);
      int waited;
      waited = 0;
      while (got_type.size() < n && waited < limit) begin
         @(posedge clki);
         waited++;
      end
      checks++;
      assert (got_type.size() >= n) else begin
         errors++;
         $display("Timed out waiting for %0d stream words, only %0d arrived",
                  n, got_type.size());
      end
      // extra cycles to catch surplus words
      repeat (20) @(posedge clki);
   endtask

   function automatic bit stream_closed();
      if (got_type.size() == 0) begin
         return 1'b0;
      end
      return got_type[got_type.size() - 1] == dtype_header_end;
   endfunction

   task automatic clear_stream();
      got_type.delete();
      got_data.delete();
      exp_type.delete();
      exp_data.delete();
      exp_chk.delete();
   endtask

   task automatic compare_stream(input string name);
      checks++;
      assert (got_type.size() == exp_type.size()) else begin
         errors++;
         $display("Fail %0t: %s gave %0d words, expected %0d",
                  $time, name, got_type.size(), exp_type.size());
      end
      for (int i = 0; i < exp_type.size() && i < got_type.size(); i++) begin
         checks++;
         assert (got_type[i] == exp_type[i] && (!exp_chk[i] || got_data[i] == exp_data[i]))
         else begin
            errors++;
            $display("Fail %0t: %s word %0d type %0d data %h, expected type %0d data %h",
                     $time, name, i, got_type[i], got_data[i], exp_type[i], exp_data[i]);
         end
      end
      clear_stream();
   endtask

   task automatic reset_state_test();
      // a frame while disabled must stay out of the stream
      play_frame(2, 4, 3);
      repeat (20) @(posedge clki);
      checks++;
      assert (got_type.size() == 0) else begin
         errors++;
         $display("Fail %0t: %0d words left while enable was low", $time, got_type.size());
      end
      check_reg(reg_addr_ctrl, 16'h0000, status_ok, "ctrl after reset");
      check_reg(8'h20, unmapped_data, status_bad_addr, "unmapped address");
      clear_stream();
   endtask

   task automatic full_frame_test();
      write_reg(reg_addr_ctrl, 16'h0001);
      check_reg(reg_addr_ctrl, 16'h0001, status_ok, "ctrl after write");
      repeat (8) @(negedge clki);
      play_frame(4, 6, 3);
      expect_frame();
      wait_words(exp_type.size(), t2_cycles);
      compare_stream("full frame");
   endtask

   task automatic mid_frame_enable_test();
      write_reg(reg_addr_ctrl, 16'h0000);
      repeat (8) @(negedge clki);
      // enable lands while fv is high
      fork
         play_frame(4, 6, 3);
         begin
            repeat (15) @(negedge clki);
            write_reg(reg_addr_ctrl, 16'h0001);
         end
      join
      play_frame(3, 5, 3);
      expect_frame();
      wait_words(exp_type.size(), t3_cycles);
      compare_stream("frame after mid-frame enable");
   endtask

   task automatic back_pressure_test();
      int waited;
      @(posedge clki);
      withhold = 1'b1;
      // small frame fits the buffer while the stall holds the header
      play_frame(2, 2, 3);
      expect_frame();
      repeat (10) @(posedge clki);
      checks++;
      assert (got_type.size() <= `FIFO_CREDITS) else begin
         errors++;
         $display("Fail %0t: %0d words sent with no credits returned, limit %0d",
                  $time, got_type.size(), `FIFO_CREDITS);
      end
      withhold = 1'b0;
      wait_words(exp_type.size(), t4_cycles);
      compare_stream("credit back-pressure");
      // long row with no credits overflows
      withhold = 1'b1;
      play_frame(1, 20, 3);
      check_reg(reg_addr_status, 16'h0001, status_ok, "status after overflow");
      check_reg(reg_addr_status, 16'h0000, status_ok, "status second read");
      @(posedge clki);
      withhold = 1'b0;
      waited = 0;
      while (!stream_closed() && waited < t4_cycles) begin
         @(posedge clki);
         waited++;
      end
      checks++;
      assert (stream_closed()) else begin
         errors++;
         $display("Header end never arrived after the overflow frame drained");
      end
      repeat (20) @(posedge clki);
      clear_stream();
   endtask

   task automatic register_readback_test();
      play_frame(3, 5, 3);
      expect_frame();
      play_frame(5, 7, 4);
      expect_frame();
      wait_words(exp_type.size(), t5_cycles);
      compare_stream("two frames");
      check_reg(reg_addr_frame_count, 16'(frames_driven), status_ok, "frame_count");
      check_reg(reg_addr_num_rows, 16'(last_rows), status_ok, "num_rows");
      check_reg(reg_addr_num_cols, 16'(last_cols), status_ok, "num_cols");
      check_reg(reg_addr_checksum, pixel_sum(), status_ok, "checksum");
      // lv period is the row length plus its gap
      check_reg(reg_addr_clks_per_row, 16'(last_cols + last_gap), status_ok, "clks_per_row");
   endtask

   initial begin
      resetb    = 1'b0;
      fv        = 1'b0;
      lv        = 1'b0;
      pixel     = '0;
      reg_addr  = '0;
      reg_wr    = 1'b0;
      reg_wdata = '0;
      reg_rd    = 1'b0;
      repeat (16) @(posedge clki);
      @(negedge clki);
      resetb = 1'b1;
      reset_state_test();
      full_frame_test();
      mid_frame_enable_test();
      back_pressure_test();
      register_readback_test();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // watchdog over the summed test budgets
   initial begin
      repeat (watchdog_cycles) @(posedge clki);
      $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
      $display("Test failures found");
      $finish;
   end

endmodule

/* imager_top.f */
+incdir+hdl
hdl/stream_pkg.sv
hdl/reg_pkg.sv
hdl/imager_rx.sv
hdl/image_header.sv
hdl/reg_port.sv
hdl/credit_fifo.sv
hdl/imager_top.sv
bench/imager_top_tb.sv

/* Makefile */
# Verilator build and run of the imager testbench

VERILATOR ?= verilator
TOP       ?= imager_top_tb
FILELIST  ?= imager_top.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# status comes from the search for the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
